// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f src.f \
		--top-module cpu_core_tb -o cpu_core_sim
	./obj_dir/cpu_core_sim 2>&1 | tee sim.log
	! grep -q '>>> FAIL' sim.log
	grep -q '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core(
	input  logic        clk,
	input  logic        rst,
	input  logic        instr_valid,
	input  logic [31:0] instr,
	output logic        wb_valid,
	output logic [4:0]  wb_reg,
	output logic [31:0] wb_data
);
	import cpu_pkg::*;

	reg_addr_t raddr_a;
	reg_addr_t raddr_b;
	uint32_t   rdata_a;
	uint32_t   rdata_b;
	logic      rf_we;
	reg_addr_t rf_waddr;
	uint32_t   rf_wdata;
	logic      fwd_valid;
	reg_addr_t fwd_dest;
	uint32_t   fwd_data;
	uint64_t   hilo;

	issue_if  issue_bus();
	result_if result_bus();

	regfile regfile_inst(
		.clk,
		.rst,
		.raddr_a,
		.raddr_b,
		.rdata_a,
		.rdata_b,
		.we    ( rf_we    ),
		.waddr ( rf_waddr ),
		.wdata ( rf_wdata )
	);

	instr_decode decode_inst(
		.clk,
		.rst,
		.instr_valid,
		.instr,
		.raddr_a,
		.raddr_b,
		.rdata_a,
		.rdata_b,
		.ex_fwd_valid ( fwd_valid  ),
		.ex_fwd_dest  ( fwd_dest   ),
		.ex_fwd_data  ( fwd_data   ),
		.issue        ( issue_bus  ),
		.res          ( result_bus )
	);

	instr_exec exec_inst(
		.clk,
		.rst,
		.issue ( issue_bus  ),
		.hilo,
		.fwd_valid,
		.fwd_dest,
		.fwd_data,
		.res   ( result_bus )
	);

	write_back write_back_inst(
		.clk,
		.rst,
		.res ( result_bus ),
		.rf_we,
		.rf_waddr,
		.rf_wdata,
		.hilo,
		.wb_valid,
		.wb_reg,
		.wb_data
	);

endmodule

// ==== hw/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// general purpose registers
`define REG_NUM 32

// datapath width
`define DATA_WIDTH 32

// register index width
`define REG_ADDR_WIDTH 5

`endif

// ==== hw/cpu_pkg.sv ====
`include "cpu_params.svh"

package cpu_pkg;

typedef logic [`DATA_WIDTH-1:0]     uint32_t;
typedef logic [2*`DATA_WIDTH-1:0]   uint64_t;
typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

// one instruction word, two views
typedef union packed {
	struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r;
	struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i;
} instr_t;

typedef enum logic [4:0] {
	OP_NOP, OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
	OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
	OP_MULT, OP_MULTU, OP_MFHI, OP_MFLO, OP_LUI
} exec_op_t;

// decoder output before operand read
typedef struct packed {
	exec_op_t  op;
	logic      use_imm;
	uint32_t   imm;
	reg_addr_t dest;
	logic      reg_write;
} decoded_t;

// primary opcodes
localparam logic [5:0] OPC_SPECIAL = 6'h00;
localparam logic [5:0] OPC_ADDIU   = 6'h09;
localparam logic [5:0] OPC_SLTI    = 6'h0a;
localparam logic [5:0] OPC_SLTIU   = 6'h0b;
localparam logic [5:0] OPC_ANDI    = 6'h0c;
localparam logic [5:0] OPC_ORI     = 6'h0d;
localparam logic [5:0] OPC_XORI    = 6'h0e;
localparam logic [5:0] OPC_LUI     = 6'h0f;

endpackage

// ==== hw/instr_decode.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module instr_decode(
	input  logic               clk,
	input  logic               rst,
	input  logic               instr_valid,
	input  cpu_pkg::instr_t    instr,
	output cpu_pkg::reg_addr_t raddr_a,
	output cpu_pkg::reg_addr_t raddr_b,
	input  cpu_pkg::uint32_t   rdata_a,
	input  cpu_pkg::uint32_t   rdata_b,
	input  logic               ex_fwd_valid,
	input  cpu_pkg::reg_addr_t ex_fwd_dest,
	input  cpu_pkg::uint32_t   ex_fwd_data,
	issue_if.source            issue,
	result_if.snoop            res
);
	import cpu_pkg::*;

	logic     instr_valid_q;
	instr_t   instr_q;
	decoded_t dec;
	uint32_t  opnd_a;
	uint32_t  opnd_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			instr_valid_q <= 1'b0;
		end else begin
			instr_valid_q <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			instr_q <= instr;
		end
	end

	assign raddr_a = instr_q.r.rs;
	assign raddr_b = instr_q.r.rt;

	always_comb begin
		dec = '0;
		dec.op = OP_NOP;
		dec.imm = {{(`DATA_WIDTH-16){instr_q.i.imm[15]}}, instr_q.i.imm};
		if (instr_q.r.opcode == OPC_SPECIAL) begin
			dec.dest = instr_q.r.rd;
			case (instr_q.r.funct)
				6'h00: dec.op = OP_SLL;
				6'h02: dec.op = OP_SRL;
				6'h03: dec.op = OP_SRA;
				6'h10: dec.op = OP_MFHI;
				6'h12: dec.op = OP_MFLO;
				6'h18: dec.op = OP_MULT;
				6'h19: dec.op = OP_MULTU;
				6'h21: dec.op = OP_ADDU;
				6'h23: dec.op = OP_SUBU;
				6'h24: dec.op = OP_AND;
				6'h25: dec.op = OP_OR;
				6'h26: dec.op = OP_XOR;
				6'h27: dec.op = OP_NOR;
				6'h2a: dec.op = OP_SLT;
				6'h2b: dec.op = OP_SLTU;
				default: dec.op = OP_NOP;
			endcase
		end else begin
			dec.dest = instr_q.i.rt;
			dec.use_imm = 1'b1;
			case (instr_q.i.opcode)
				OPC_ADDIU: dec.op = OP_ADDU;
				OPC_SLTI:  dec.op = OP_SLT;
				OPC_SLTIU: dec.op = OP_SLTU;
				OPC_ANDI:  dec.op = OP_AND;
				OPC_ORI:   dec.op = OP_OR;
				OPC_XORI:  dec.op = OP_XOR;
				OPC_LUI:   dec.op = OP_LUI;
				default:   dec.op = OP_NOP;
			endcase
			// logic ops take the immediate zero extended
			if (dec.op == OP_AND || dec.op == OP_OR || dec.op == OP_XOR) begin
				dec.imm = {{(`DATA_WIDTH-16){1'b0}}, instr_q.i.imm};
			end else if (dec.op == OP_LUI) begin
				dec.imm = {instr_q.i.imm, 16'h0000};
			end
		end
		dec.reg_write = !(dec.op == OP_NOP || dec.op == OP_MULT || dec.op == OP_MULTU)
			&& dec.dest != '0;
	end

	// youngest producer wins
	function automatic uint32_t pick_operand(input reg_addr_t addr, input uint32_t rf_val);
		if (addr == '0) begin
			return '0;
		end
		if (ex_fwd_valid && ex_fwd_dest == addr) begin
			return ex_fwd_data;
		end
		if (res.valid && res.reg_write && res.dest == addr) begin
			return res.wdata;
		end
		return rf_val;
	endfunction

	always_comb begin
		opnd_a = pick_operand(instr_q.r.rs, rdata_a);
		opnd_b = dec.use_imm ? dec.imm : pick_operand(instr_q.r.rt, rdata_b);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= instr_valid_q;
		end
	end

	always_ff @(posedge clk) begin
		issue.op <= dec.op;
		issue.src_a <= opnd_a;
		issue.src_b <= opnd_b;
		issue.shamt <= instr_q.r.shamt;
		issue.dest <= dec.dest;
		issue.reg_write <= dec.reg_write;
	end

endmodule

// ==== hw/instr_exec.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module instr_exec(
	input  logic               clk,
	input  logic               rst,
	issue_if.sink              issue,
	input  cpu_pkg::uint64_t   hilo,
	output logic               fwd_valid,
	output cpu_pkg::reg_addr_t fwd_dest,
	output cpu_pkg::uint32_t   fwd_data,
	result_if.source           res
);
	import cpu_pkg::*;

	uint64_t                       hilo_cur;
	logic signed [2*`DATA_WIDTH-1:0] prod_s;
	uint64_t                       prod_u;
	uint64_t                       hilo_new;
	uint32_t                       result;
	logic                          is_mul;

	// a multiply one slot ahead has not reached the HI/LO register yet
	assign hilo_cur = (res.valid && res.hilo_write) ? res.hilo_wdata : hilo;

	assign prod_s = $signed(issue.src_a) * $signed(issue.src_b);
	assign prod_u = {{`DATA_WIDTH{1'b0}}, issue.src_a} * {{`DATA_WIDTH{1'b0}}, issue.src_b};

	assign is_mul = issue.op == OP_MULT || issue.op == OP_MULTU;

	always_comb begin
		result = '0;
		hilo_new = '0;
		case (issue.op)
			OP_ADDU:  result = issue.src_a + issue.src_b;
			OP_SUBU:  result = issue.src_a - issue.src_b;
			OP_AND:   result = issue.src_a & issue.src_b;
			OP_OR:    result = issue.src_a | issue.src_b;
			OP_XOR:   result = issue.src_a ^ issue.src_b;
			OP_NOR:   result = ~(issue.src_a | issue.src_b);
			OP_SLT:   result = uint32_t'($signed(issue.src_a) < $signed(issue.src_b));
			OP_SLTU:  result = uint32_t'(issue.src_a < issue.src_b);
			// shifts act on rt
			OP_SLL:   result = issue.src_b << issue.shamt;
			OP_SRL:   result = issue.src_b >> issue.shamt;
			OP_SRA:   result = uint32_t'($signed(issue.src_b) >>> issue.shamt);
			OP_LUI:   result = issue.src_b;
			OP_MFHI:  result = hilo_cur[2*`DATA_WIDTH-1:`DATA_WIDTH];
			OP_MFLO:  result = hilo_cur[`DATA_WIDTH-1:0];
			OP_MULT:  hilo_new = prod_s;
			OP_MULTU: hilo_new = prod_u;
			default:  result = '0;
		endcase
	end

	assign fwd_valid = issue.valid && issue.reg_write;
	assign fwd_dest = issue.dest;
	assign fwd_data = result;

	always_ff @(posedge clk) begin
		if (rst) begin
			res.valid <= 1'b0;
		end else begin
			res.valid <= issue.valid;
		end
	end

	always_ff @(posedge clk) begin
		res.dest <= issue.dest;
		res.reg_write <= issue.reg_write;
		res.wdata <= result;
		res.hilo_write <= is_mul;
		res.hilo_wdata <= hilo_new;
	end

endmodule

// ==== hw/pipe_if.sv ====
`timescale 1ns/10ps

// decode to execute
interface issue_if;
	import cpu_pkg::*;

	logic       valid;
	exec_op_t   op;
	uint32_t    src_a;
	uint32_t    src_b;
	logic [4:0] shamt;
	reg_addr_t  dest;
	logic       reg_write;

	modport source(output valid, op, src_a, src_b, shamt, dest, reg_write);
	modport sink(input valid, op, src_a, src_b, shamt, dest, reg_write);
endinterface

// execute to result stage
interface result_if;
	import cpu_pkg::*;

	logic      valid;
	reg_addr_t dest;
	logic      reg_write;
	uint32_t   wdata;
	logic      hilo_write;
	uint64_t   hilo_wdata;

	modport source(output valid, dest, reg_write, wdata, hilo_write, hilo_wdata);
	modport sink(input valid, dest, reg_write, wdata, hilo_write, hilo_wdata);

	// decode only needs the register side for forwarding
	modport snoop(input valid, dest, reg_write, wdata);
endinterface

// ==== hw/regfile.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module regfile(
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::reg_addr_t raddr_a,
	input  cpu_pkg::reg_addr_t raddr_b,
	output cpu_pkg::uint32_t   rdata_a,
	output cpu_pkg::uint32_t   rdata_b,
	input  logic               we,
	input  cpu_pkg::reg_addr_t waddr,
	input  cpu_pkg::uint32_t   wdata
);
	import cpu_pkg::*;

	uint32_t regs [`REG_NUM];

	always_ff @(posedge clk) begin
		if (rst) begin
			regs <= '{default: '0};
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 is never written, so it reads zero
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

// ==== hw/write_back.sv ====
`timescale 1ns/10ps

module write_back(
	input  logic               clk,
	input  logic               rst,
	result_if.sink             res,
	output logic               rf_we,
	output cpu_pkg::reg_addr_t rf_waddr,
	output cpu_pkg::uint32_t   rf_wdata,
	output cpu_pkg::uint64_t   hilo,
	output logic               wb_valid,
	output cpu_pkg::reg_addr_t wb_reg,
	output cpu_pkg::uint32_t   wb_data
);
	import cpu_pkg::*;

	uint64_t hilo_q;

	// HI in the upper word
	always_ff @(posedge clk) begin
		if (rst) begin
			hilo_q <= '0;
		end else if (res.valid && res.hilo_write) begin
			hilo_q <= res.hilo_wdata;
		end
	end

	assign hilo = hilo_q;

	assign rf_we = res.valid && res.reg_write;
	assign rf_waddr = res.dest;
	assign rf_wdata = res.wdata;

	// report mirrors the regfile write
	assign wb_valid = rf_we;
	assign wb_reg = res.dest;
	assign wb_data = res.wdata;

endmodule

// ==== src.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/pipe_if.sv
hw/regfile.sv
hw/instr_decode.sv
hw/instr_exec.sv
hw/write_back.sv
hw/cpu_core.sv
test/cpu_core_sva.sv
test/cpu_core_tb.sv

// ==== test/cpu_core_sva.sv ====
`timescale 1ns/10ps

module cpu_core_sva(
	input logic       clk,
	input logic       rst,
	input logic       instr_valid,
	input logic       wb_valid,
	input logic [4:0] wb_reg
);

	// quiet through reset and one cycle past it
	reset_quiet: assert property (@(posedge clk) rst |=> !wb_valid)
		else $error("write reported during reset");

	after_reset_quiet: assert property (@(posedge clk) $fell(rst) |=> !wb_valid)
		else $error("write reported right after reset");

	no_r0_report: assert property (@(posedge clk) disable iff (rst) wb_valid |-> wb_reg != '0)
		else $error("write to r0 reported");

	// fixed latency of three edges
	report_latency: assert property (@(posedge clk) disable iff (rst)
		wb_valid |-> $past(instr_valid, 3))
		else $error("report without an instruction taken three edges earlier");

endmodule

bind cpu_core cpu_core_sva cpu_core_sva_inst(
	.clk         ( clk         ),
	.rst         ( rst         ),
	.instr_valid ( instr_valid ),
	.wb_valid    ( wb_valid    ),
	.wb_reg      ( wb_reg      )
);

// ==== test/cpu_core_tb.sv ====
`timescale 1ns/10ps

module cpu_core_tb;

	localparam int NUM_DIRECTED = 12;
	localparam int NUM_SLOTS = 2000;
	// one slot per 4 ns clock plus reset and drain
	localparam int WATCHDOG_NS = (NUM_DIRECTED + NUM_SLOTS + 20) * 4;

	// ADDU SUBU AND OR XOR NOR SLT SLTU SLL SRL SRA MULT MULTU MFHI MFLO
	localparam logic [5:0] R_FUNCTS [15] = '{
		6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b,
		6'h00, 6'h02, 6'h03, 6'h18, 6'h19, 6'h10, 6'h12
	};

	typedef struct packed {
		logic [31:0][31:0] regs;
		logic [63:0]       hilo;
	} model_t;

	typedef struct packed {
		logic [4:0]  dest;
		logic [31:0] value;
		int          edge_no;
	} expect_t;

	logic        clk;
	logic        rst;
	logic        instr_valid;
	logic [31:0] instr;
	logic        wb_valid;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;

	model_t  model;
	expect_t exp_q[$];
	int      edge_cnt = 0;

	cpu_core cpu_core_inst(
		.clk,
		.rst,
		.instr_valid,
		.instr,
		.wb_valid,
		.wb_reg,
		.wb_data
	);

	always #2 clk = ~clk;

	task automatic end_in_failure();
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("Error at %0t: %s", $time, msg);
		end_in_failure();
	endtask

	task automatic value_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end_in_failure();
	endtask

	function automatic logic [31:0] r_word(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, funct};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// reset values, immediate extension, forwarding at distance 1 to 3, HI/LO, r0 write
	function automatic logic [31:0] directed_instr(input int idx);
		case (idx)
			0:  return r_word(6'h12, 5'd0, 5'd0, 5'd1, 5'd0);
			1:  return r_word(6'h25, 5'd0, 5'd0, 5'd2, 5'd0);
			2:  return i_word(6'h09, 5'd0, 5'd3, 16'h8001);
			3:  return i_word(6'h0e, 5'd3, 5'd4, 16'h8001);
			4:  return i_word(6'h0f, 5'd0, 5'd5, 16'h8000);
			5:  return r_word(6'h18, 5'd3, 5'd5, 5'd0, 5'd0);
			6:  return r_word(6'h10, 5'd0, 5'd0, 5'd6, 5'd0);
			7:  return r_word(6'h12, 5'd0, 5'd0, 5'd7, 5'd0);
			8:  return r_word(6'h19, 5'd3, 5'd5, 5'd0, 5'd0);
			9:  return r_word(6'h10, 5'd0, 5'd0, 5'd1, 5'd0);
			10: return r_word(6'h21, 5'd3, 5'd4, 5'd0, 5'd0);
			default: return r_word(6'h23, 5'd6, 5'd7, 5'd2, 5'd0);
		endcase
	endfunction

	function automatic logic [31:0] random_instr();
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [31:0] word;
		int unsigned sel;
		rs = 5'($urandom_range(0, 7));
		rt = 5'($urandom_range(0, 7));
		rd = 5'($urandom_range(0, 7));
		sel = $urandom_range(0, 23);
		if (sel < 15) begin
			word = r_word(R_FUNCTS[4'(sel)], rs, rt, rd, 5'($urandom()));
		end else if (sel < 22) begin
			word = i_word(6'(6'h09 + sel - 15), rs, rt, 16'($urandom()));
		end else if (sel == 22) begin
			// trapping ADD is outside the subset
			word = r_word(6'h20, rs, rt, rd, 5'd0);
		end else begin
			word = $urandom();
			if (word[31:26] == 6'h00 || (word[31:26] >= 6'h09 && word[31:26] <= 6'h0f)) begin
				word[31:26] = 6'h1c;
			end
		end
		return word;
	endfunction

	// architectural effect of one instruction
	// returns 1 when a write is reported
	function automatic logic model_step(input logic [31:0] word, input model_t cur,
			output model_t nxt, output logic [4:0] dest, output logic [31:0] value);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] zext;
		logic        wr;
		nxt = cur;
		a = cur.regs[word[25:21]];
		b = cur.regs[word[20:16]];
		sext = {{16{word[15]}}, word[15:0]};
		zext = {16'h0000, word[15:0]};
		value = '0;
		wr = 1'b1;
		if (word[31:26] == 6'h00) begin
			dest = word[15:11];
			case (word[5:0])
				6'h00: value = b << word[10:6];
				6'h02: value = b >> word[10:6];
				6'h03: value = $signed(b) >>> word[10:6];
				6'h10: value = cur.hilo[63:32];
				6'h12: value = cur.hilo[31:0];
				6'h18: begin
					nxt.hilo = {{32{a[31]}}, a} * {{32{b[31]}}, b};
					wr = 1'b0;
				end
				6'h19: begin
					nxt.hilo = {32'h0, a} * {32'h0, b};
					wr = 1'b0;
				end
				6'h21: value = a + b;
				6'h23: value = a - b;
				6'h24: value = a & b;
				6'h25: value = a | b;
				6'h26: value = a ^ b;
				6'h27: value = ~(a | b);
				6'h2a: value = {31'b0, $signed(a) < $signed(b)};
				6'h2b: value = {31'b0, a < b};
				default: wr = 1'b0;
			endcase
		end else begin
			dest = word[20:16];
			case (word[31:26])
				6'h09: value = a + sext;
				6'h0a: value = {31'b0, $signed(a) < $signed(sext)};
				6'h0b: value = {31'b0, a < sext};
				6'h0c: value = a & zext;
				6'h0d: value = a | zext;
				6'h0e: value = a ^ zext;
				6'h0f: value = {word[15:0], 16'h0000};
				default: wr = 1'b0;
			endcase
		end
		if (wr && dest != 5'd0) begin
			nxt.regs[dest] = value;
		end
		return wr && dest != 5'd0;
	endfunction

	initial begin : stimulus
		logic [31:0] word;
		logic        slot_valid;
		logic [4:0]  dest;
		logic [31:0] value;
		model_t      nxt;
		expect_t     e;
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		model = '0;
		void'($urandom(21367));
		repeat (2) @(posedge clk);
		#0.5;
		rst = 1'b0;
		for (int i = 0; i < NUM_DIRECTED + NUM_SLOTS; i++) begin
			if (i < NUM_DIRECTED) begin
				word = directed_instr(i);
				slot_valid = 1'b1;
			end else begin
				word = random_instr();
				slot_valid = ($urandom_range(0, 3) != 0);
			end
			instr = word;
			instr_valid = slot_valid;
			if (slot_valid) begin
				if (model_step(word, model, nxt, dest, value)) begin
					e.dest = dest;
					e.value = value;
					// reported three edges after the coming edge
					e.edge_no = edge_cnt + 4;
					exp_q.push_back(e);
				end
				model = nxt;
			end
			@(posedge clk);
			#0.5;
		end
		instr_valid = 1'b0;
		repeat (4) @(posedge clk);
		if (exp_q.size() == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			abort_run("expected register writes were never reported");
		end
	end

	always @(posedge clk) begin : compare
		expect_t e;
		edge_cnt = edge_cnt + 1;
		if (!rst) begin
			assert (!$isunknown(wb_valid)) else abort_run("wb_valid is unknown after reset");
			if (wb_valid) begin
				assert (exp_q.size() > 0) else abort_run("a write was reported with none expected");
				e = exp_q.pop_front();
				assert (wb_reg == e.dest) else value_mismatch("wb_reg", 32'(e.dest), 32'(wb_reg));
				assert (wb_data == e.value) else value_mismatch("wb_data", e.value, wb_data);
				assert (edge_cnt == e.edge_no)
					else abort_run("a write was reported at the wrong cycle");
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		abort_run("watchdog timeout, the run did not finish");
	end

endmodule
